/* common/renaming_defs.svh */
`ifndef RENAMING_DEFS_SVH
`define RENAMING_DEFS_SVH

// Instructions renamed per cycle.
`define MACHINE_WIDTH 2

// Architectural and physical register file sizes.
`define AREG_COUNT 32
`define PREG_COUNT 64

// RAT read ports for src1, src2 and old dst of each slot.
`define RAT_READ_PORTS (3 * `MACHINE_WIDTH)

`endif

/* common/common.sv */
`include "renaming_defs.svh"

package common;

    typedef logic [$clog2(`AREG_COUNT)-1:0] areg_addr_t;
    typedef logic [$clog2(`PREG_COUNT)-1:0] preg_addr_t;

    typedef struct packed {
        logic       reg_write;    // Writes dst.
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       jump;
        logic       alu_src;
        logic [1:0] alu_op;
    } ctl_t;

    typedef struct packed {
        areg_addr_t src1;
        areg_addr_t src2;
        areg_addr_t dst;
    } instr_t;

    typedef struct packed {
        instr_t      instr;
        ctl_t        ctl;
        logic [31:0] imm;
        logic [31:0] pcplus8;
        logic        exception;
    } decode_data_t;

    typedef struct packed {
        preg_addr_t  dst;
        preg_addr_t  src1;
        preg_addr_t  src2;
        preg_addr_t  old_dst;
        areg_addr_t  dst_;
        areg_addr_t  src1_;
        areg_addr_t  src2_;
        ctl_t        ctl;
        logic [31:0] imm;
        logic [31:0] pcplus8;
        logic        exception;
    } renaming_data_t;

    typedef decode_data_t   [`MACHINE_WIDTH-1:0] decode_group_t;
    typedef renaming_data_t [`MACHINE_WIDTH-1:0] renaming_group_t;

endpackage

/* common/renaming_pkg.sv */
`include "renaming_defs.svh"

package renaming_pkg;

    import common::*;

    // One RAT lookup.
    typedef struct packed {
        areg_addr_t areg;
    } rat_read_t;

    // Lookup results in read port order.
    typedef preg_addr_t [`RAT_READ_PORTS-1:0] rat_resp_t;

    // One new mapping applied at the edge.
    typedef struct packed {
        logic       en;
        areg_addr_t areg;
        preg_addr_t preg;
    } rat_write_t;

    // Register handed back by commit.
    typedef struct packed {
        logic       valid;
        preg_addr_t preg;
    } release_t;

endpackage

/* logic/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // Data stays put while hold is high.
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

/* renaming/rat.sv */
`timescale 1ns/1ps
`include "renaming_defs.svh"

module rat
    import common::*;
    import renaming_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  rat_read_t [`RAT_READ_PORTS-1:0]  read,
    output rat_resp_t                        resp,
    input  rat_write_t [`MACHINE_WIDTH-1:0]  write
);

    preg_addr_t map_q [`AREG_COUNT];

    always_comb begin
        for (int i = 0; i < `RAT_READ_PORTS; i++) begin
            resp[i] = map_q[read[i].areg];
        end
    end

    // Later slot overrides on the same areg.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `AREG_COUNT; i++) begin
                map_q[i] <= preg_addr_t'(i);  // Identity map.
            end
        end else begin
            for (int i = 0; i < `MACHINE_WIDTH; i++) begin
                if (write[i].en && (write[i].areg != '0)) begin
                    map_q[write[i].areg] <= write[i].preg;
                end
            end
        end
    end

endmodule

/* renaming/free_list.sv */
`timescale 1ns/1ps
`include "renaming_defs.svh"

module free_list
    import common::*;
    import renaming_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`MACHINE_WIDTH-1:0]     alloc,
    output preg_addr_t [`MACHINE_WIDTH-1:0] alloc_preg,
    output logic                          can_alloc,
    input  release_t [`MACHINE_WIDTH-1:0] rel
);

    localparam int W     = `MACHINE_WIDTH;
    localparam int DEPTH = `PREG_COUNT - `AREG_COUNT;

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;
    typedef logic [$clog2(W+1)-1:0]     ofs_t;

    preg_addr_t entries [DEPTH];
    ptr_t       head;
    ptr_t       tail;
    cnt_t       count;
    ptr_t       rel_slot [W];
    ofs_t       num_alloc;
    ofs_t       num_rel;

    assign can_alloc = count >= cnt_t'(W);

    // Allocating slots pack onto consecutive entries from head.
    always_comb begin
        ofs_t a_cnt;
        ofs_t r_cnt;
        a_cnt = '0;
        r_cnt = '0;
        for (int i = 0; i < W; i++) begin
            alloc_preg[i] = entries[head + ptr_t'(a_cnt)];
            rel_slot[i]   = tail + ptr_t'(r_cnt);
            a_cnt = a_cnt + ofs_t'(alloc[i]);
            r_cnt = r_cnt + ofs_t'(rel[i].valid);
        end
        num_alloc = a_cnt;
        num_rel   = r_cnt;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= preg_addr_t'(`AREG_COUNT + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= cnt_t'(DEPTH);  // Everything above the arch regs.
        end else begin
            for (int i = 0; i < W; i++) begin
                if (rel[i].valid) begin
                    entries[rel_slot[i]] <= rel[i].preg;
                end
            end
            head  <= head + ptr_t'(num_alloc);
            tail  <= tail + ptr_t'(num_rel);
            count <= count - cnt_t'(num_alloc) + cnt_t'(num_rel);
        end
    end

endmodule

/* renaming/raw_check.sv */
`timescale 1ns/1ps
`include "renaming_defs.svh"

module raw_check
    import common::*;
(
    input  areg_addr_t [`MACHINE_WIDTH-1:0] src1,
    input  areg_addr_t [`MACHINE_WIDTH-1:0] src2,
    input  areg_addr_t [`MACHINE_WIDTH-1:0] dst,
    input  logic       [`MACHINE_WIDTH-1:0] alloc,
    input  preg_addr_t [`MACHINE_WIDTH-1:0] psrc1_rat,
    input  preg_addr_t [`MACHINE_WIDTH-1:0] psrc2_rat,
    input  preg_addr_t [`MACHINE_WIDTH-1:0] pold_rat,
    input  preg_addr_t [`MACHINE_WIDTH-1:0] pdst_fl,
    output preg_addr_t [`MACHINE_WIDTH-1:0] psrc1,
    output preg_addr_t [`MACHINE_WIDTH-1:0] psrc2,
    output preg_addr_t [`MACHINE_WIDTH-1:0] pold
);

    // Walk older slots in order, so the youngest match wins.
    always_comb begin
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            psrc1[i] = psrc1_rat[i];
            psrc2[i] = psrc2_rat[i];
            pold[i]  = pold_rat[i];
            for (int j = 0; j < i; j++) begin
                if (alloc[j] && (dst[j] == src1[i])) psrc1[i] = pdst_fl[j];
                if (alloc[j] && (dst[j] == src2[i])) psrc2[i] = pdst_fl[j];
                if (alloc[j] && (dst[j] == dst[i]))  pold[i]  = pdst_fl[j];
            end
        end
    end

endmodule

/* renaming/renaming.sv */
`timescale 1ns/1ps
`include "renaming_defs.svh"

module renaming
    import common::*;
    import renaming_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  decode_group_t                 in_group,
    input  release_t [`MACHINE_WIDTH-1:0] commit_release,
    output logic                          stall,
    output logic                          new_valid,
    output renaming_group_t               new_group
);

    localparam int W = `MACHINE_WIDTH;

    rat_read_t  [`RAT_READ_PORTS-1:0] rat_read;
    rat_resp_t                        rat_resp;
    rat_write_t [W-1:0]               rat_write;
    logic       [W-1:0]               alloc;
    preg_addr_t [W-1:0]               fl_preg;
    logic                             can_alloc;
    areg_addr_t [W-1:0]               src1;
    areg_addr_t [W-1:0]               src2;
    areg_addr_t [W-1:0]               dst;
    preg_addr_t [W-1:0]               psrc1;
    preg_addr_t [W-1:0]               psrc2;
    preg_addr_t [W-1:0]               pold;

    assign stall     = in_valid && !can_alloc;
    assign new_valid = in_valid && !stall;

    always_comb begin
        for (int i = 0; i < W; i++) begin
            src1[i] = in_group[i].instr.src1;
            src2[i] = in_group[i].instr.src2;
            dst[i]  = in_group[i].instr.dst;

            // r0 is hardwired, never renamed.
            alloc[i] = new_valid && in_group[i].ctl.reg_write && (dst[i] != '0);

            rat_read[i].areg       = src1[i];
            rat_read[W + i].areg   = src2[i];
            rat_read[2*W + i].areg = dst[i];

            rat_write[i].en   = alloc[i];
            rat_write[i].areg = dst[i];
            rat_write[i].preg = fl_preg[i];
        end
    end

    rat rat (
        .clk   (clk),
        .reset (reset),
        .read  (rat_read),
        .resp  (rat_resp),
        .write (rat_write)
    );

    free_list free_list (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_preg (fl_preg),
        .can_alloc  (can_alloc),
        .rel        (commit_release)
    );

    raw_check raw_check (
        .src1      (src1),
        .src2      (src2),
        .dst       (dst),
        .alloc     (alloc),
        .psrc1_rat (rat_resp[W-1:0]),
        .psrc2_rat (rat_resp[2*W-1:W]),
        .pold_rat  (rat_resp[3*W-1:2*W]),
        .pdst_fl   (fl_preg),
        .psrc1     (psrc1),
        .psrc2     (psrc2),
        .pold      (pold)
    );

    always_comb begin
        for (int i = 0; i < W; i++) begin
            new_group[i].dst       = alloc[i] ? fl_preg[i] : '0;
            new_group[i].src1      = psrc1[i];
            new_group[i].src2      = psrc2[i];
            new_group[i].old_dst   = alloc[i] ? pold[i] : '0;
            new_group[i].dst_      = dst[i];
            new_group[i].src1_     = src1[i];
            new_group[i].src2_     = src2[i];
            new_group[i].ctl       = in_group[i].ctl;
            new_group[i].imm       = in_group[i].imm;
            new_group[i].pcplus8   = in_group[i].pcplus8;
            new_group[i].exception = in_group[i].exception;
        end
    end

endmodule

/* logic/renaming_top.sv */
`timescale 1ns/1ps
`include "renaming_defs.svh"

module renaming_top
    import common::*;
    import renaming_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dec_valid,
    input  decode_group_t                      dec_group,
    input  release_t [`MACHINE_WIDTH-1:0]      commit_release,
    output logic                               stall,
    output logic                               ren_valid,
    output renaming_group_t                    ren_group
);

    logic            rreg_valid;
    decode_group_t   rreg_group;
    logic            new_valid;
    renaming_group_t new_group;

    pipe_reg #(.payload_t(decode_group_t)) rreg (
        .clk       (clk),
        .reset     (reset),
        .hold      (stall),      // Keep the group until free regs arrive.
        .in_valid  (dec_valid),
        .in_data   (dec_group),
        .out_valid (rreg_valid),
        .out_data  (rreg_group)
    );

    renaming renaming (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (rreg_valid),
        .in_group       (rreg_group),
        .commit_release (commit_release),
        .stall          (stall),
        .new_valid      (new_valid),
        .new_group      (new_group)
    );

    pipe_reg #(.payload_t(renaming_group_t)) ireg (
        .clk       (clk),
        .reset     (reset),
        .hold      (1'b0),
        .in_valid  (new_valid),
        .in_data   (new_group),
        .out_valid (ren_valid),
        .out_data  (ren_group)
    );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #4 clk = ~clk;  // 8 ns period.

endmodule

/* verification/renaming_tb.sv */
`timescale 1ns/1ps
`include "renaming_defs.svh"

module renaming_tb
    import common::*;
    import renaming_pkg::*;
();

    localparam int W              = `MACHINE_WIDTH;
    localparam int NUM_GROUPS     = 300;
    localparam int TIMEOUT_CYCLES = NUM_GROUPS * 4 + 200;

    logic              clk;
    logic              reset;
    logic              dec_valid;
    decode_group_t     dec_group;
    release_t [W-1:0]  commit_release;
    logic              stall;
    logic              ren_valid;
    renaming_group_t   ren_group;

    logic [31:0]       lcg_state = 32'd61286;
    int                value_errors = 0;
    int                other_errors = 0;

    // Reference model state.
    preg_addr_t        m_rat [`AREG_COUNT];
    preg_addr_t        free_q [$];
    preg_addr_t        retire_q [$];
    renaming_group_t   exp_q [$];
    logic              m_rreg_valid;
    decode_group_t     m_rreg_group;

    tb_clock clock_gen (.clk(clk));

    renaming_top dut (
        .clk            (clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .dec_group      (dec_group),
        .commit_release (commit_release),
        .stall          (stall),
        .ren_valid      (ren_valid),
        .ren_group      (ren_group)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic decode_group_t make_group();
        decode_group_t g;
        logic [31:0]   r;
        for (int i = 0; i < W; i++) begin
            r = lcg_next();
            g[i].instr.src1    = r[31:27];
            g[i].instr.src2    = r[26:22];
            g[i].instr.dst     = r[21:17];
            g[i].ctl           = ctl_t'(r[16:9]);
            g[i].ctl.reg_write = (r[15:14] != 2'b00);  // Roughly 75%.
            g[i].exception     = (r[13:10] == 4'd0);
            g[i].imm           = lcg_next();
            g[i].pcplus8       = lcg_next();
        end
        // Intra-group dependencies on the previous slot.
        for (int i = 1; i < W; i++) begin
            r = lcg_next();
            if (r[31:30] == 2'b00) g[i].instr.src1 = g[i-1].instr.dst;
            if (r[29:28] == 2'b00) g[i].instr.src2 = g[i-1].instr.dst;
            if (r[27:25] == 3'b000) g[i].instr.dst = g[i-1].instr.dst;
        end
        return g;
    endfunction

    // Slots rename one after another, each seeing the mappings of the older ones.
    task automatic rename_model(input decode_group_t g);
        renaming_group_t r;
        for (int i = 0; i < W; i++) begin
            r[i].src1 = m_rat[g[i].instr.src1];
            r[i].src2 = m_rat[g[i].instr.src2];
            if (g[i].ctl.reg_write && (g[i].instr.dst != '0)) begin
                r[i].old_dst = m_rat[g[i].instr.dst];
                r[i].dst     = free_q.pop_front();
                m_rat[g[i].instr.dst] = r[i].dst;
                if (r[i].old_dst != '0) retire_q.push_back(r[i].old_dst);
            end else begin
                r[i].dst     = '0;
                r[i].old_dst = '0;
            end
            r[i].dst_      = g[i].instr.dst;
            r[i].src1_     = g[i].instr.src1;
            r[i].src2_     = g[i].instr.src2;
            r[i].ctl       = g[i].ctl;
            r[i].imm       = g[i].imm;
            r[i].pcplus8   = g[i].pcplus8;
            r[i].exception = g[i].exception;
        end
        exp_q.push_back(r);
    endtask

    // Every other 64 cycles no commits, so the free list runs dry.
    task automatic pick_releases(input int cycle, output release_t [W-1:0] rel);
        logic [31:0] r;
        r   = lcg_next();
        rel = '0;
        for (int i = 0; i < W; i++) begin
            if ((cycle % 128 < 64) && (r[31-2*i -: 2] != 2'b00) && (retire_q.size() > 0)) begin
                rel[i].valid = 1'b1;
                rel[i].preg  = retire_q.pop_front();
            end
        end
    endtask

    task automatic check_group(input renaming_group_t got, input renaming_group_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail ren_group: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail stall: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_ren_output();
        if (ren_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Renamed group appeared while no group was expected");
            end else begin
                check_group(ren_group, exp_q.pop_front());
            end
        end else if (exp_q.size() > 0) begin
            other_errors++;
            $display("Renamed group did not arrive two edges after acceptance");
            exp_q.delete(0);
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired before all groups were renamed");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic             stall_exp;
        logic             next_valid;
        decode_group_t    next_group;
        release_t [W-1:0] next_rel;
        logic [31:0]      r;
        int               sent;
        int               renamed;
        int               cycle;
        sent           = 0;
        renamed        = 0;
        cycle          = 0;
        reset          = 1'b1;
        dec_valid      = 1'b0;
        dec_group      = '0;
        commit_release = '0;
        m_rreg_valid   = 1'b0;
        m_rreg_group   = '0;
        for (int i = 0; i < `AREG_COUNT; i++) m_rat[i] = preg_addr_t'(i);
        for (int i = `AREG_COUNT; i < `PREG_COUNT; i++) free_q.push_back(preg_addr_t'(i));

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        while ((renamed < NUM_GROUPS) || (exp_q.size() > 0)) begin
            @(negedge clk);
            check_ren_output();
            stall_exp = m_rreg_valid && (free_q.size() < W);
            check_stall(stall, stall_exp);

            // Predict the coming edge. Rename first, then commits join the free list.
            if (m_rreg_valid && !stall_exp) begin
                rename_model(m_rreg_group);
                renamed++;
            end
            for (int i = 0; i < W; i++) begin
                if (commit_release[i].valid) free_q.push_back(commit_release[i].preg);
            end
            if (!stall_exp) begin
                m_rreg_valid = dec_valid;
                m_rreg_group = dec_group;
                if (dec_valid) sent++;
            end

            next_valid = dec_valid;  // Held during stall.
            next_group = dec_group;
            if (!stall_exp) begin
                r          = lcg_next();
                next_valid = (sent < NUM_GROUPS) && (r[31:30] != 2'b00);
                next_group = make_group();
            end
            pick_releases(cycle, next_rel);
            cycle++;

            @(posedge clk);
            dec_valid      <= next_valid;
            dec_group      <= next_group;
            commit_release <= next_rel;
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/common.sv
common/renaming_pkg.sv
logic/pipe_reg.sv
renaming/rat.sv
renaming/free_list.sv
renaming/raw_check.sv
renaming/renaming.sv
logic/renaming_top.sv
verification/tb_clock.sv
verification/renaming_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module renaming_tb -f filelist.f -o renaming_sim

out=$(./obj_dir/renaming_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
